// ==== src.f ====
verilog/id_pkg.sv
verilog/id_fwd_if.sv
verilog/register_file.sv
verilog/main_control.sv
verilog/branch_forward_unit.sv
verilog/decode_stage.sv
verilog/id_top.sv
test/id_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module id_tb -f src.f -o id_sim || exit 1

out=$(./obj_dir/id_sim)
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1

// ==== test/id_tb.sv ====
// **************************************
// Decode stage testbench
// Table of instructions and write-back
// traffic checked against a local model
// **************************************

module id_tb import id_pkg::*;
    ();

    typedef struct packed {
        word_t     instr;
        word_t     npc;
        word_t     alu_m;       // Memory-stage ALU result
        logic      wr_m;
        reg_addr_t dst_m;
        logic      wr_w;        // Write-back port
        reg_addr_t dst_w;
        word_t     data_w;
    } row_t;

    logic      i_clk;
    logic      i_rst;
    word_t     i_instruction;
    word_t     i_npc;
    word_t     i_alu_result_m;
    logic      i_reg_write_m;
    reg_addr_t i_write_reg_m;
    logic      i_reg_write_w;
    reg_addr_t i_write_reg_w;
    word_t     i_write_data_w;
    word_t     o_jump_addr;
    word_t     o_branch_addr;
    word_t     o_read_data_1;
    word_t     o_read_data_2;
    word_t     o_instr_imm;
    reg_addr_t o_instr_rs;
    reg_addr_t o_instr_rt;
    reg_addr_t o_instr_rd;
    logic      o_pc_src;
    logic      o_jump;
    logic      o_reg_write;
    logic      o_reg_dst;
    logic      o_alu_src;
    logic      o_mem_read;
    logic      o_mem_write;
    logic      o_mem_to_reg;
    alu_op_t   o_alu_op;

    row_t        rows [$];
    word_t       shadow [32];       // Model of the register contents
    int          errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 20;
    int unsigned seed_init;

    id_top UUT (.*);

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic word_t make_rtype(input reg_addr_t rs, input reg_addr_t rt,
                                         input reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, 6'h20};     // add rd, rs, rt
    endfunction

    function automatic word_t make_itype(input opcode_t op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(input word_t instr, input word_t npc, input word_t alu_m,
                           input logic wr_m, input reg_addr_t dst_m, input logic wr_w,
                           input reg_addr_t dst_w, input word_t data_w);
        rows.push_back({instr, npc, alu_m, wr_m, dst_m, wr_w, dst_w, data_w});
    endtask

    task automatic build_table();
        word_t     val_a;
        word_t     val_b;
        reg_addr_t dst;
        reg_addr_t written [10];
        opcode_t   ops [8];
        // Every register straight after reset
        for (int k = 0; k < 16; k++) begin
            add_row(make_rtype(reg_addr_t'(2 * k), reg_addr_t'(2 * k + 1), 5'd0),
                    '0, '0, 1'b0, '0, 1'b0, '0, '0);
        end
        for (int k = 0; k < 10; k++) begin
            dst = reg_addr_t'($urandom_range(31, 1));
            written[k] = dst;
            add_row(make_rtype(reg_addr_t'($urandom), reg_addr_t'($urandom), dst),
                    $urandom, '0, 1'b0, '0, 1'b1, dst, $urandom);
        end
        for (int k = 0; k < 10; k++) begin
            add_row(make_rtype(written[k], written[9 - k], 5'd1),
                    $urandom, '0, 1'b0, '0, 1'b0, '0, '0);
        end
        // r0 write, read in the same cycle and the next
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b1, 5'd0, $urandom);
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b1, 5'd0, $urandom);
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b0, '0, '0);
        // Bypass on each read port
        add_row(make_rtype(5'd9, 5'd3, 5'd2), '0, '0, 1'b0, '0, 1'b1, 5'd9, $urandom);
        add_row(make_rtype(5'd4, 5'd10, 5'd2), '0, '0, 1'b0, '0, 1'b1, 5'd10, $urandom);
        // Immediates of both signs and varied npc region bits
        add_row(make_itype(OP_ADDI, 5'd1, 5'd2, 16'h1234), 32'h0040_0010,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_ADDI, 5'd1, 5'd2, 16'h8004), 32'hf000_0100,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_SW, 5'd3, 5'd4, 16'hffff), 32'h3fff_fffc,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_LW, 5'd3, 5'd4, 16'($urandom)), 32'h8000_0000 | $urandom,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row({OP_J, 26'($urandom)}, 32'ha000_0000, '0, 1'b0, '0, 1'b0, '0, '0);
        add_row({OP_J, 26'h3ff_ffff}, 32'h5000_0008, '0, 1'b0, '0, 1'b0, '0, '0);
        // Operands for the branch compare, r5 == r6 != r7
        val_a = $urandom;
        val_b = val_a ^ ($urandom | 32'h1);
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b1, 5'd5, val_a);
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b1, 5'd6, val_a);
        add_row(make_rtype(5'd0, 5'd0, 5'd0), '0, '0, 1'b0, '0, 1'b1, 5'd7, val_b);
        add_row(make_itype(OP_BEQ, 5'd5, 5'd6, 16'($urandom)), $urandom,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_BEQ, 5'd5, 5'd7, 16'($urandom)), $urandom,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_BNE, 5'd5, 5'd7, 16'($urandom)), $urandom,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_BNE, 5'd5, 5'd6, 16'($urandom)), $urandom,
                '0, 1'b0, '0, 1'b0, '0, '0);
        add_row(make_itype(OP_BEQ, 5'd5, 5'd7, 16'h0010), $urandom,
                val_b, 1'b1, 5'd5, 1'b0, '0, '0);           // Forward on rs
        add_row(make_itype(OP_BNE, 5'd5, 5'd6, 16'h0020), $urandom,
                val_b, 1'b1, 5'd6, 1'b0, '0, '0);           // Forward on rt
        add_row(make_itype(OP_BEQ, 5'd0, 5'd7, 16'h0030), $urandom,
                val_b, 1'b1, 5'd0, 1'b0, '0, '0);           // Destination r0
        add_row(make_itype(OP_BEQ, 5'd5, 5'd7, 16'h0040), $urandom,
                val_b, 1'b0, 5'd5, 1'b0, '0, '0);           // No write in memory stage
        // Each opcode of the decode table plus one unknown
        ops = '{OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_BNE, OP_J, 6'h3f};
        for (int k = 0; k < 8; k++) begin
            add_row(make_itype(ops[k], reg_addr_t'($urandom), reg_addr_t'($urandom),
                    16'($urandom)), $urandom, '0, 1'b0, '0, 1'b0, '0, '0);
        end
        for (int k = 0; k < 6; k++) begin
            add_row($urandom, $urandom, '0, 1'b0, '0, 1'b0, '0, '0);
        end
    endtask

    // {jump, reg_write, reg_dst, alu_src, mem_read, mem_write, mem_to_reg, alu_op}
    function automatic logic [8:0] expected_controls(input opcode_t op);
        case (op)
            OP_RTYPE:       return {7'b0110000, ALU_FUNCT};
            OP_ADDI:        return {7'b0101000, ALU_ADD};
            OP_LW:          return {7'b0101101, ALU_ADD};
            OP_SW:          return {7'b0001010, ALU_ADD};
            OP_BEQ, OP_BNE: return {7'b0000000, ALU_SUB};
            OP_J:           return {7'b1000000, 2'b00};
            default:        return 9'b0;
        endcase
    endfunction

    // Register read as seen in the cycle of row r, pending write included
    function automatic word_t expected_read(input reg_addr_t addr, input row_t r);
        if (addr == 5'd0) begin
            return '0;
        end
        if (r.wr_w && (r.dst_w == addr)) begin
            return r.data_w;
        end
        return shadow[addr];
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_row(input row_t r);
        reg_addr_t  rs;
        reg_addr_t  rt;
        word_t      imm;
        word_t      rd1;
        word_t      rd2;
        logic       taken;
        logic [8:0] ctrl;
        rs = r.instr[25:21];
        rt = r.instr[20:16];
        imm = {16'h0000, r.instr[15:0]};
        if (r.instr[15]) begin
            imm = imm - 32'h0001_0000;                      // Two's complement value
        end
        rd1 = expected_read(rs, r);
        rd2 = expected_read(rt, r);
        if (r.wr_m && (r.dst_m != 5'd0) && (r.dst_m == rs)) begin
            rd1 = r.alu_m;
        end
        if (r.wr_m && (r.dst_m != 5'd0) && (r.dst_m == rt)) begin
            rd2 = r.alu_m;
        end
        taken = ((r.instr[31:26] == OP_BEQ) && (rd1 == rd2)) ||
                ((r.instr[31:26] == OP_BNE) && (rd1 != rd2));
        ctrl = expected_controls(r.instr[31:26]);
        check_value("o_instr_rs", word_t'(o_instr_rs), word_t'(rs));
        check_value("o_instr_rt", word_t'(o_instr_rt), word_t'(rt));
        check_value("o_instr_rd", word_t'(o_instr_rd), word_t'(r.instr[15:11]));
        check_value("o_instr_imm", o_instr_imm, imm);
        check_value("o_branch_addr", o_branch_addr, r.npc + imm * 4);
        check_value("o_jump_addr", o_jump_addr, {r.npc[31:28], r.instr[25:0], 2'b00});
        check_value("o_read_data_1", o_read_data_1, rd1);
        check_value("o_read_data_2", o_read_data_2, rd2);
        check_value("o_pc_src", word_t'(o_pc_src), word_t'(taken));
        check_value("o_jump", word_t'(o_jump), word_t'(ctrl[8]));
        check_value("o_reg_write", word_t'(o_reg_write), word_t'(ctrl[7]));
        check_value("o_reg_dst", word_t'(o_reg_dst), word_t'(ctrl[6]));
        check_value("o_alu_src", word_t'(o_alu_src), word_t'(ctrl[5]));
        check_value("o_mem_read", word_t'(o_mem_read), word_t'(ctrl[4]));
        check_value("o_mem_write", word_t'(o_mem_write), word_t'(ctrl[3]));
        check_value("o_mem_to_reg", word_t'(o_mem_to_reg), word_t'(ctrl[2]));
        check_value("o_alu_op", word_t'(o_alu_op), word_t'(ctrl[1:0]));
    endtask

    task automatic drive_row(input row_t r);
        i_instruction  <= r.instr;
        i_npc          <= r.npc;
        i_alu_result_m <= r.alu_m;
        i_reg_write_m  <= r.wr_m;
        i_write_reg_m  <= r.dst_m;
        i_reg_write_w  <= r.wr_w;
        i_write_reg_w  <= r.dst_w;
        i_write_data_w <= r.data_w;
    endtask

    initial begin
        i_clk          = 1'b0;
        i_rst          = 1'b1;
        i_instruction  = '0;
        i_npc          = '0;
        i_alu_result_m = '0;
        i_reg_write_m  = 1'b0;
        i_write_reg_m  = '0;
        i_reg_write_w  = 1'b0;
        i_write_reg_w  = '0;
        i_write_data_w = '0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        seed_init = $urandom(32'h0fac5109);
        build_table();
        cycle_limit = 2 * rows.size() + 20;

        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        for (int n = 0; n < rows.size(); n++) begin
            if (n > 0) begin
                @(posedge i_clk);
            end
            drive_row(rows[n]);
            @(negedge i_clk);                               // Inputs settled
            check_row(rows[n]);
            if (rows[n].wr_w && (rows[n].dst_w != 5'd0)) begin
                shadow[rows[n].dst_w] = rows[n].data_w;     // Stored at the next edge
            end
        end
        @(posedge i_clk);

        $display("Done: %0d rows applied, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog/id_top.sv ====
// **************************************
// Decode stage top level
// Register file, main control, branch
// forwarding and the decode datapath
// **************************************

module id_top import id_pkg::*;
    (
        input  logic      i_clk,
        input  logic      i_rst,
        input  word_t     i_instruction,
        input  word_t     i_npc,
        input  word_t     i_alu_result_m,     // Memory-stage ALU result
        input  logic      i_reg_write_m,
        input  reg_addr_t i_write_reg_m,
        input  logic      i_reg_write_w,      // Write-back port
        input  reg_addr_t i_write_reg_w,
        input  word_t     i_write_data_w,
        output word_t     o_jump_addr,
        output word_t     o_branch_addr,
        output word_t     o_read_data_1,
        output word_t     o_read_data_2,
        output word_t     o_instr_imm,
        output reg_addr_t o_instr_rs,
        output reg_addr_t o_instr_rt,
        output reg_addr_t o_instr_rd,
        output logic      o_pc_src,
        output logic      o_jump,
        output logic      o_reg_write,
        output logic      o_reg_dst,
        output logic      o_alu_src,
        output logic      o_mem_read,
        output logic      o_mem_write,
        output logic      o_mem_to_reg,
        output alu_op_t   o_alu_op
    );

    word_t rf_data_1;
    word_t rf_data_2;
    logic  branch;
    logic  equal;

    id_fwd_if fwd ();

    assign o_instr_rs = fwd.rs;
    assign o_instr_rt = fwd.rt;

    register_file u_register_file (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_read_reg_1  (fwd.rs),
        .i_read_reg_2  (fwd.rt),
        .i_reg_write   (i_reg_write_w),
        .i_write_reg   (i_write_reg_w),
        .i_write_data  (i_write_data_w),
        .o_read_data_1 (rf_data_1),
        .o_read_data_2 (rf_data_2)
    );

    main_control u_main_control (
        .i_opcode     (i_instruction[OP_MSB -: OP_W]),
        .o_branch     (branch),
        .o_equal      (equal),
        .o_jump       (o_jump),
        .o_reg_write  (o_reg_write),
        .o_reg_dst    (o_reg_dst),
        .o_alu_src    (o_alu_src),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_mem_to_reg (o_mem_to_reg),
        .o_alu_op     (o_alu_op)
    );

    branch_forward_unit u_branch_forward_unit (
        .i_reg_write_m (i_reg_write_m),
        .i_write_reg_m (i_write_reg_m),
        .fwd           (fwd)
    );

    decode_stage u_decode_stage (
        .i_instruction  (i_instruction),
        .i_npc          (i_npc),
        .i_alu_result_m (i_alu_result_m),
        .i_read_data_1  (rf_data_1),
        .i_read_data_2  (rf_data_2),
        .i_branch       (branch),
        .i_equal        (equal),
        .fwd            (fwd),
        .o_jump_addr    (o_jump_addr),
        .o_branch_addr  (o_branch_addr),
        .o_read_data_1  (o_read_data_1),
        .o_read_data_2  (o_read_data_2),
        .o_instr_imm    (o_instr_imm),
        .o_pc_src       (o_pc_src),
        .o_instr_rd     (o_instr_rd)
    );

endmodule

// ==== verilog/decode_stage.sv ====
// **************************************
// Instruction decode datapath
// Field split, immediate extension,
// branch and jump targets, forwarded
// compare and the PC source decision
// **************************************

module decode_stage import id_pkg::*;
    (
        input  word_t     i_instruction,
        input  word_t     i_npc,              // PC + 4 of this instruction
        input  word_t     i_alu_result_m,     // Forwarded from memory stage
        input  word_t     i_read_data_1,      // Register file port 1
        input  word_t     i_read_data_2,      // Register file port 2
        input  logic      i_branch,
        input  logic      i_equal,
        id_fwd_if.stage   fwd,
        output word_t     o_jump_addr,
        output word_t     o_branch_addr,
        output word_t     o_read_data_1,      // Operand A after forwarding
        output word_t     o_read_data_2,      // Operand B after forwarding
        output word_t     o_instr_imm,        // Sign-extended immediate
        output logic      o_pc_src,           // Take the branch
        output reg_addr_t o_instr_rd
    );

    localparam int PC_HI_W = WORD_W - JUMP_IDX_W - 2;

    word_t ext_imm;
    word_t operand_a;
    word_t operand_b;
    logic  operands_equal;

    // Register fields
    assign fwd.rs     = i_instruction[RS_MSB -: REG_W];
    assign fwd.rt     = i_instruction[RT_MSB -: REG_W];
    assign o_instr_rd = i_instruction[RD_MSB -: REG_W];

    assign ext_imm = {{(WORD_W - IMM_W){i_instruction[IMM_W-1]}},
                      i_instruction[IMM_W-1:0]};
    assign o_instr_imm = ext_imm;

    // Word offset, so scale by four
    assign o_branch_addr = i_npc + (ext_imm << 2);

    // Region bits of npc, then the word index
    assign o_jump_addr = {i_npc[WORD_W-1 -: PC_HI_W],
                          i_instruction[JUMP_IDX_W-1:0],
                          2'b00};

    // Result still in flight in memory stage
    assign operand_a = fwd.forward_a ? i_alu_result_m : i_read_data_1;
    assign operand_b = fwd.forward_b ? i_alu_result_m : i_read_data_2;

    assign o_read_data_1 = operand_a;
    assign o_read_data_2 = operand_b;

    assign operands_equal = (operand_a == operand_b);

    // beq wants equal, bne wants unequal
    assign o_pc_src = i_branch && (operands_equal == i_equal);

endmodule

// ==== verilog/branch_forward_unit.sv ====
// **************************************
// Branch forwarding unit
// Routes the memory-stage ALU result to
// the branch compare in decode
// **************************************

module branch_forward_unit import id_pkg::*;
    (
        input  logic      i_reg_write_m,    // Memory stage will write back
        input  reg_addr_t i_write_reg_m,    // Memory stage destination
        id_fwd_if.unit    fwd
    );

    logic dest_live;

    // r0 results are discarded, so they are never forwarded
    assign dest_live = i_reg_write_m && (i_write_reg_m != '0);

    assign fwd.forward_a = dest_live && (i_write_reg_m == fwd.rs);
    assign fwd.forward_b = dest_live && (i_write_reg_m == fwd.rt);

    // The decode stage owns rs and rt, so this ties both sides together
    always_comb begin
        a_no_r0_fwd: assert (!(fwd.forward_a && fwd.rs == '0) &&
                             !(fwd.forward_b && fwd.rt == '0))
            else $error("branch_forward_unit: forward raised for r0");
    end

endmodule

// ==== verilog/main_control.sv ====
// **************************************
// Main control decoder
// Turns the opcode into branch, jump and
// datapath control lines
// **************************************

module main_control import id_pkg::*;
    (
        input  opcode_t i_opcode,
        output logic    o_branch,       // Conditional branch
        output logic    o_equal,        // High for beq, low for bne
        output logic    o_jump,
        output logic    o_reg_write,
        output logic    o_reg_dst,      // Destination is rd, not rt
        output logic    o_alu_src,      // ALU operand B is the immediate
        output logic    o_mem_read,
        output logic    o_mem_write,
        output logic    o_mem_to_reg,   // Write back the load data
        output alu_op_t o_alu_op
    );

    always_comb begin
        o_branch     = 1'b0;
        o_equal      = 1'b0;
        o_jump       = 1'b0;
        o_reg_write  = 1'b0;
        o_reg_dst    = 1'b0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_alu_op     = '0;              // Also for j and unknown opcodes

        case (i_opcode)
            OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_reg_dst   = 1'b1;
                o_alu_op    = ALU_FUNCT;
            end
            OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
                o_alu_op    = ALU_ADD;
            end
            OP_LW: begin
                o_reg_write  = 1'b1;
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_alu_op     = ALU_ADD;     // Address calculation
            end
            OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                o_alu_op    = ALU_ADD;
            end
            OP_BEQ: begin
                o_branch = 1'b1;
                o_equal  = 1'b1;
                o_alu_op = ALU_SUB;
            end
            OP_BNE: begin
                o_branch = 1'b1;
                o_alu_op = ALU_SUB;
            end
            OP_J: begin
                o_jump = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Memory port sees at most one access per instruction
    always_comb begin
        a_mem_excl: assert (!(o_mem_read && o_mem_write))
            else $error("main_control: read and write together");
    end

endmodule

// ==== verilog/register_file.sv ====
// **************************************
// Register file, 32 words of 32 bits
// Two async read ports, one clocked write
// port, r0 tied to zero, write bypass
// **************************************

module register_file import id_pkg::*;
    (
        input  logic      i_clk,
        input  logic      i_rst,
        input  reg_addr_t i_read_reg_1,     // Read port 1 address
        input  reg_addr_t i_read_reg_2,     // Read port 2 address
        input  logic      i_reg_write,      // Write strobe from write-back
        input  reg_addr_t i_write_reg,      // Write address
        input  word_t     i_write_data,     // Write data
        output word_t     o_read_data_1,
        output word_t     o_read_data_2
    );

    word_t regs [REG_NUM];
    logic  write_en;

    // r0 is never a legal destination
    assign write_en = i_reg_write && (i_write_reg != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // One read port, with the pending write bypassed to the output
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;                          // r0 reads zero
        end else if (write_en && (addr == i_write_reg)) begin
            data = i_write_data;                // Write-through
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign o_read_data_1 = read_port(i_read_reg_1);
    assign o_read_data_2 = read_port(i_read_reg_2);

    // A write aimed at r0 must leave storage untouched
    a_r0_stays_zero: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_reg_write && (i_write_reg == '0)) |=> (regs[0] == '0)
    ) else $error("register_file: r0 was written");

endmodule

// ==== verilog/id_fwd_if.sv ====
// **************************************
// Branch forwarding link between the
// decode stage and the forwarding unit
// **************************************

interface id_fwd_if import id_pkg::*;
    ();

    reg_addr_t rs;          // Source register A of the branch compare
    reg_addr_t rt;          // Source register B of the branch compare
    logic      forward_a;   // Take memory-stage result for operand A
    logic      forward_b;   // Take memory-stage result for operand B

    modport stage (
        output rs,
        output rt,
        input  forward_a,
        input  forward_b
    );

    modport unit (
        input  rs,
        input  rt,
        output forward_a,
        output forward_b
    );

endinterface

// ==== verilog/id_pkg.sv ====
// **************************************
// Decode stage definitions
// Word and field widths, opcodes and
// ALU operation classes for MIPS32
// **************************************

package id_pkg;

    localparam int WORD_W     = 32;            // Instruction and data word
    localparam int REG_W      = 5;             // Register number
    localparam int OP_W       = 6;             // Opcode field
    localparam int REG_NUM    = 1 << REG_W;    // Architectural registers

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [1:0]        alu_op_t;

    // Field positions in the instruction word
    localparam int OP_MSB     = 31;
    localparam int RS_MSB     = 25;
    localparam int RT_MSB     = 20;
    localparam int RD_MSB     = 15;
    localparam int IMM_W      = 16;            // Immediate, I-type
    localparam int JUMP_IDX_W = 26;            // Target index, J-type

    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_J     = 6'd2;
    localparam opcode_t OP_BEQ   = 6'd4;
    localparam opcode_t OP_BNE   = 6'd5;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SW    = 6'd43;

    // Operation class handed to the ALU control
    localparam alu_op_t ALU_ADD   = 2'b00;
    localparam alu_op_t ALU_SUB   = 2'b01;
    localparam alu_op_t ALU_FUNCT = 2'b10;

endpackage
